//--- Makefile
# Verilator flow for the RV32I decode stage
# Override on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_decode
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= project.f
VFLAGS    ?= --timing
PASS_MSG  := === PASS ===

.PHONY: all lint sim clean

all: sim

# Static checks over the whole file list
lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# Build, run from the project root so the vector path resolves, then scan the log
sim:
	rm -f $(LOG)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qxF -- "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hdl/decode.sv
`timescale 1ns/1ps

module decode import rv_pkg::*; (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            valid_i,      // Sampled every rising edge
    input  insn_u           insn_i,
    input  logic [XLEN-1:0] pc_i,
    output decoded_t        dec_o,        // One cycle after valid_i
    output logic            dec_valid_o
);

    fields_t         fields;   // Register and function fields
    logic [XLEN-1:0] imm;      // Sign-extended immediate

    // Both decoders see the same word in parallel
    reg_field_decode u_reg_field_decode (
        .insn_i   (insn_i),
        .fields_o (fields)
    );

    imm_gen u_imm_gen (
        .insn_i (insn_i),
        .imm_o  (imm)
    );

    // Single register stage for the whole record
    decode_output_stage u_output_stage (
        .clk         (clk),
        .reset_i     (reset_i),
        .valid_i     (valid_i),
        .pc_i        (pc_i),
        .insn_i      (insn_i),
        .fields_i    (fields),
        .imm_i       (imm),
        .dec_o       (dec_o),
        .dec_valid_o (dec_valid_o)
    );

endmodule : decode

//--- hdl/decode_output_stage.sv
`timescale 1ns/1ps

module decode_output_stage import rv_pkg::*; (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            valid_i,
    input  logic [XLEN-1:0] pc_i,
    input  insn_u           insn_i,
    input  fields_t         fields_i,
    input  logic [XLEN-1:0] imm_i,
    output decoded_t        dec_o,
    output logic            dec_valid_o
);

    decoded_t rec_d; // Record assembled this cycle

    // Merge field decoder result with immediate, PC and raw word
    always_comb begin
        rec_d.pc      = pc_i;
        rec_d.insn    = insn_i;          // Raw word, no view needed
        rec_d.opcode  = insn_i.r.opcode;
        rec_d.rd      = fields_i.rd;
        rec_d.rs1     = fields_i.rs1;
        rec_d.rs2     = fields_i.rs2;
        rec_d.funct3  = fields_i.funct3;
        rec_d.funct7  = fields_i.funct7;
        rec_d.shamt   = fields_i.shamt;
        rec_d.fmt     = fields_i.fmt;
        rec_d.illegal = fields_i.illegal;
        rec_d.imm     = imm_i;
    end

    // Valid follows the input strobe every cycle
    // Record only moves on a valid cycle and holds through bubbles
    always_ff @(posedge clk) begin
        if (reset_i) begin
            dec_valid_o <= 1'b0;
            dec_o       <= '0;
        end else begin
            dec_valid_o <= valid_i;
            if (valid_i) begin
                dec_o <= rec_d;
            end
        end
    end

endmodule : decode_output_stage

//--- hdl/imm_gen.sv
`timescale 1ns/1ps

module imm_gen import rv_pkg::*; (
    input  insn_u           insn_i,
    output logic [XLEN-1:0] imm_o
);

    // Per-format immediates, all sign-extended from instruction bit 31
    logic [XLEN-1:0] imm_i_fmt;
    logic [XLEN-1:0] imm_s_fmt;
    logic [XLEN-1:0] imm_b_fmt;
    logic [XLEN-1:0] imm_u_fmt;
    logic [XLEN-1:0] imm_j_fmt;

    assign imm_i_fmt = {{(XLEN-12){insn_i.i.imm_11_0[11]}}, insn_i.i.imm_11_0};

    // Upper and lower pieces split around rs1, rs2 and funct3
    assign imm_s_fmt = {{(XLEN-12){insn_i.s.imm_11_5[6]}},
                        insn_i.s.imm_11_5,
                        insn_i.s.imm_4_0};

    // Branch offset is in halfwords, so bit 0 is always zero
    assign imm_b_fmt = {{(XLEN-13){insn_i.b.imm_12}},
                        insn_i.b.imm_12,
                        insn_i.b.imm_11,   // Lives at instruction bit 7
                        insn_i.b.imm_10_5,
                        insn_i.b.imm_4_1,
                        1'b0};

    assign imm_u_fmt = {insn_i.u.imm_31_12, 12'b0}; // Upper 20 bits, low 12 zero

    // Jump offset scrambled across the upper 20 bits
    assign imm_j_fmt = {{(XLEN-21){insn_i.j.imm_20}},
                        insn_i.j.imm_20,
                        insn_i.j.imm_19_12,
                        insn_i.j.imm_11,
                        insn_i.j.imm_10_1,
                        1'b0};

    // Own opcode classification since the format does not cross over
    always_comb begin
        case (insn_i.r.opcode)
            OPCODE_OP_IMM, OPCODE_LOAD, OPCODE_JALR: imm_o = imm_i_fmt;
            OPCODE_STORE:                            imm_o = imm_s_fmt;
            OPCODE_BRANCH:                           imm_o = imm_b_fmt;
            OPCODE_LUI, OPCODE_AUIPC:                imm_o = imm_u_fmt;
            OPCODE_JAL:                              imm_o = imm_j_fmt;
            default:                                 imm_o = '0; // R-type and unknown
        endcase
    end

endmodule : imm_gen

//--- hdl/reg_field_decode.sv
`timescale 1ns/1ps

module reg_field_decode import rv_pkg::*; (
    input  insn_u   insn_i,
    output fields_t fields_o
);

    logic is_shift; // OP-IMM with SLLI, SRLI or SRAI

    // Opcode and funct3 sit at the same place in every view
    assign is_shift = (insn_i.i.opcode == OPCODE_OP_IMM) &&
                      ((insn_i.i.funct3 == FUNCT3_SLL) ||
                       (insn_i.i.funct3 == FUNCT3_SRL_SRA));

    always_comb begin
        fields_o = '0; // Fields a format does not use stay zero
        fields_o.fmt = FMT_UNKNOWN;

        case (insn_i.r.opcode)
            // Register-register ALU ops
            OPCODE_OP: begin
                fields_o.fmt    = FMT_R;
                fields_o.rd     = insn_i.r.rd;
                fields_o.rs1    = insn_i.r.rs1;
                fields_o.rs2    = insn_i.r.rs2;
                fields_o.funct3 = insn_i.r.funct3;
                fields_o.funct7 = insn_i.r.funct7;
            end

            // Immediate ALU ops, loads and JALR share the I layout
            OPCODE_OP_IMM, OPCODE_LOAD, OPCODE_JALR: begin
                fields_o.fmt    = FMT_I;
                fields_o.rd     = insn_i.i.rd;
                fields_o.rs1    = insn_i.i.rs1;
                fields_o.funct3 = insn_i.i.funct3;
                if (is_shift) begin
                    // Upper immediate bits read as funct7 and shamt
                    fields_o.funct7 = insn_i.r.funct7;
                    fields_o.shamt  = insn_i.r.rs2;
                end
            end

            // Stores write no register
            OPCODE_STORE: begin
                fields_o.fmt    = FMT_S;
                fields_o.rs1    = insn_i.s.rs1;
                fields_o.rs2    = insn_i.s.rs2;
                fields_o.funct3 = insn_i.s.funct3;
            end

            OPCODE_BRANCH: begin
                fields_o.fmt    = FMT_B;
                fields_o.rs1    = insn_i.b.rs1;    // Compare operand A
                fields_o.rs2    = insn_i.b.rs2;    // Compare operand B
                fields_o.funct3 = insn_i.b.funct3; // Condition
            end

            // LUI and AUIPC carry only rd and the immediate
            OPCODE_LUI, OPCODE_AUIPC: begin
                fields_o.fmt = FMT_U;
                fields_o.rd  = insn_i.u.rd;
            end

            OPCODE_JAL: begin
                fields_o.fmt = FMT_J;
                fields_o.rd  = insn_i.j.rd; // Link register
            end

            // Unknown opcode
            // Every field passed raw for later analysis
            default: begin
                fields_o.illegal = 1'b1;
                fields_o.rd      = insn_i.r.rd;
                fields_o.rs1     = insn_i.r.rs1;
                fields_o.rs2     = insn_i.r.rs2;
                fields_o.funct3  = insn_i.r.funct3;
                fields_o.funct7  = insn_i.r.funct7;
                fields_o.shamt   = insn_i.r.rs2; // Same bits as rs2
            end
        endcase
    end

endmodule : reg_field_decode

//--- hdl/rv_pkg.sv
package rv_pkg;

    localparam int XLEN     = 32; // Data and address width
    localparam int REG_AW   = 5;  // Register index width
    localparam int OPCODE_W = 7;
    localparam int FUNCT3_W = 3;
    localparam int FUNCT7_W = 7;

    `include "rv_constants.svh"

    // Instruction formats, unknown covers everything outside RV32I base
    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_UNKNOWN
    } insn_fmt_e;

    // One view per format, MSB first
    typedef struct packed {
        logic [FUNCT7_W-1:0] funct7;
        logic [REG_AW-1:0]   rs2;    // Also the shift amount of OP-IMM shifts
        logic [REG_AW-1:0]   rs1;
        logic [FUNCT3_W-1:0] funct3;
        logic [REG_AW-1:0]   rd;
        logic [OPCODE_W-1:0] opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0]         imm_11_0;
        logic [REG_AW-1:0]   rs1;
        logic [FUNCT3_W-1:0] funct3;
        logic [REG_AW-1:0]   rd;
        logic [OPCODE_W-1:0] opcode;
    } i_view_t;

    typedef struct packed {
        logic [6:0]          imm_11_5;
        logic [REG_AW-1:0]   rs2;   // Store data
        logic [REG_AW-1:0]   rs1;   // Base address
        logic [FUNCT3_W-1:0] funct3;
        logic [4:0]          imm_4_0;
        logic [OPCODE_W-1:0] opcode;
    } s_view_t;

    typedef struct packed {
        logic                imm_12;   // Sign bit
        logic [5:0]          imm_10_5;
        logic [REG_AW-1:0]   rs2;
        logic [REG_AW-1:0]   rs1;
        logic [FUNCT3_W-1:0] funct3;
        logic [3:0]          imm_4_1;
        logic                imm_11;
        logic [OPCODE_W-1:0] opcode;
    } b_view_t;

    typedef struct packed {
        logic [19:0]         imm_31_12;
        logic [REG_AW-1:0]   rd;
        logic [OPCODE_W-1:0] opcode;
    } u_view_t;

    typedef struct packed {
        logic                imm_20;   // Sign bit
        logic [9:0]          imm_10_1;
        logic                imm_11;
        logic [7:0]          imm_19_12;
        logic [REG_AW-1:0]   rd;
        logic [OPCODE_W-1:0] opcode;
    } j_view_t;

    // Same word, read through whichever format the consumer needs
    typedef union packed {
        r_view_t r;
        i_view_t i;
        s_view_t s;
        b_view_t b;
        u_view_t u;
        j_view_t j;
    } insn_u;

    // Field decoder result, unused fields already zeroed
    typedef struct packed {
        logic [REG_AW-1:0]   rd;
        logic [REG_AW-1:0]   rs1;
        logic [REG_AW-1:0]   rs2;
        logic [FUNCT3_W-1:0] funct3;
        logic [FUNCT7_W-1:0] funct7;
        logic [REG_AW-1:0]   shamt;
        insn_fmt_e           fmt;
        logic                illegal; // Opcode outside the supported set
    } fields_t;

    // Registered decode record handed to the next stage
    typedef struct packed {
        logic [XLEN-1:0]     pc;
        logic [XLEN-1:0]     insn;
        logic [OPCODE_W-1:0] opcode;
        logic [REG_AW-1:0]   rd;
        logic [REG_AW-1:0]   rs1;
        logic [REG_AW-1:0]   rs2;
        logic [FUNCT3_W-1:0] funct3;
        logic [FUNCT7_W-1:0] funct7;
        logic [REG_AW-1:0]   shamt;
        insn_fmt_e           fmt;
        logic                illegal;
        logic [XLEN-1:0]     imm;
    } decoded_t;

endpackage : rv_pkg

//--- include/rv_constants.svh
`ifndef RV_CONSTANTS_SVH
`define RV_CONSTANTS_SVH

// RV32I major opcodes, bits 6:0 of the instruction word

// Upper immediate group
localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;

// Control transfer
localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;

// Memory access
localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
localparam logic [6:0] OPCODE_STORE  = 7'b0100011;

// Integer ALU
localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011; // Register-immediate
localparam logic [6:0] OPCODE_OP     = 7'b0110011; // Register-register

// funct3 values that mark the OP-IMM shifts
// Shift amount sits where rs2 would be, funct7 picks logical or arithmetic
localparam logic [2:0] FUNCT3_SLL     = 3'b001;
localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101; // SRAI when funct7[5] is set

`endif

//--- project.f
+incdir+include
hdl/rv_pkg.sv
hdl/reg_field_decode.sv
hdl/imm_gen.sv
hdl/decode_output_stage.sv
hdl/decode.sv
tb/tb_decode.sv

//--- tb/decode_vectors.txt
# insn     pc       rd rs1 rs2 funct3 funct7 shamt fmt illegal imm, all hex
# fmt codes 0=R 1=I 2=S 3=B 4=U 5=J 6=unknown
002081B3 00001000 03 01 02 0 00 00 0 0 00000000
407302B3 00001004 05 06 07 0 20 00 0 0 00000000
403150B3 00001008 01 02 03 5 20 00 0 0 00000000
FFF10093 0000100C 01 02 00 0 00 00 1 0 FFFFFFFF
00729213 00001010 04 05 00 1 00 07 1 0 00000007
41F3D313 00001014 06 07 00 5 20 1F 1 0 0000041F
00355493 00001018 09 0A 00 5 00 03 1 0 00000003
7FF4F413 0000101C 08 09 00 7 00 00 1 0 000007FF
FFC5A503 00001020 0A 0B 00 2 00 00 1 0 FFFFFFFC
010280E7 00001024 01 05 00 0 00 00 1 0 00000010
00C6A423 00001028 00 0D 0C 2 00 00 2 0 00000008
FEE78623 0000102C 00 0F 0E 0 00 00 2 0 FFFFFFEC
00208863 00001030 00 01 02 0 00 00 3 0 00000010
FE419CE3 00001034 00 03 04 1 00 00 3 0 FFFFFFF8
8062C063 00001038 00 05 06 4 00 00 3 0 FFFFF000
123452B7 0000103C 05 00 00 0 00 00 4 0 12345000
FFFFF397 00001040 07 00 00 0 00 00 4 0 FFFFF000
001000EF 80000000 01 00 00 0 00 00 5 0 00000800
FFFFF06F 80000004 00 00 00 0 00 00 5 0 FFFFFFFE
800002EF FFFFFFFC 05 00 00 0 00 00 5 0 FFF00000
0FF0000F 00002000 00 00 1F 0 07 1F 6 1 00000000
305491F3 00002004 03 09 05 1 18 05 6 1 00000000
00004501 00002008 0A 00 00 4 00 00 6 1 00000000

//--- tb/tb_decode.sv
`timescale 1ns/1ps

module tb_decode import rv_pkg::*; ();

    localparam int    CLK_PERIOD = 10;      // ns
    localparam int    NUM_RANDOM = 200;
    localparam int    RESET_CYCLES = 16;
    localparam string VEC_FILE   = "tb/decode_vectors.txt";

    logic            clk;
    logic            reset_i;
    logic            valid_i;
    insn_u           insn_i;
    logic [XLEN-1:0] pc_i;
    decoded_t        dec_o;
    logic            dec_valid_o;

    // Directed vectors filled from the file at time zero
    logic [31:0] vec_insn [$];
    logic [31:0] vec_pc [$];
    decoded_t    vec_exp [$];
    bit          loaded;
    bit          load_ok;

    decoded_t    exp_q [$];    // Records driven but not yet seen
    decoded_t    held;         // What dec_o must show during a bubble
    logic        last_valid;   // valid_i driven one cycle back
    logic [31:0] rng;
    int          test_errors;
    int          pass_count;
    int          fail_count;

    decode uut (
        .clk         (clk),
        .reset_i     (reset_i),
        .valid_i     (valid_i),
        .insn_i      (insn_i),
        .pc_i        (pc_i),
        .dec_o       (dec_o),
        .dec_valid_o (dec_valid_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Nine RV32I opcodes plus SYSTEM, which the stage does not decode
    function automatic logic [6:0] pick_opcode(input logic [31:0] r);
        case (r % 32'd10)
            32'd0:   return OPCODE_LUI;
            32'd1:   return OPCODE_AUIPC;
            32'd2:   return OPCODE_JAL;
            32'd3:   return OPCODE_JALR;
            32'd4:   return OPCODE_BRANCH;
            32'd5:   return OPCODE_LOAD;
            32'd6:   return OPCODE_STORE;
            32'd7:   return OPCODE_OP_IMM;
            32'd8:   return OPCODE_OP;
            default: return 7'b1110011;
        endcase
    endfunction

    // Reference decode straight from the RV32I bit positions
    function automatic decoded_t model_decode(input logic [31:0] w, input logic [31:0] pc);
        decoded_t   d;
        logic       shift;
        d        = '0;
        d.pc     = pc;
        d.insn   = w;
        d.opcode = w[6:0];
        shift    = (w[6:0] == OPCODE_OP_IMM) &&
                   ((w[14:12] == FUNCT3_SLL) || (w[14:12] == FUNCT3_SRL_SRA));
        case (w[6:0])
            OPCODE_OP: begin
                d.fmt    = FMT_R;
                d.rd     = w[11:7];
                d.rs1    = w[19:15];
                d.rs2    = w[24:20];
                d.funct3 = w[14:12];
                d.funct7 = w[31:25];   // Immediate stays zero
            end
            OPCODE_OP_IMM, OPCODE_LOAD, OPCODE_JALR: begin
                d.fmt    = FMT_I;
                d.rd     = w[11:7];
                d.rs1    = w[19:15];
                d.funct3 = w[14:12];
                d.imm    = {{20{w[31]}}, w[31:20]};
                if (shift) begin
                    d.funct7 = w[31:25];
                    d.shamt  = w[24:20];
                end
            end
            OPCODE_STORE: begin
                d.fmt    = FMT_S;
                d.rs1    = w[19:15];
                d.rs2    = w[24:20];
                d.funct3 = w[14:12];
                d.imm    = {{20{w[31]}}, w[31:25], w[11:7]};
            end
            OPCODE_BRANCH: begin
                d.fmt    = FMT_B;
                d.rs1    = w[19:15];
                d.rs2    = w[24:20];
                d.funct3 = w[14:12];
                d.imm    = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            OPCODE_LUI, OPCODE_AUIPC: begin
                d.fmt = FMT_U;
                d.rd  = w[11:7];
                d.imm = {w[31:12], 12'b0};
            end
            OPCODE_JAL: begin
                d.fmt = FMT_J;
                d.rd  = w[11:7];
                d.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            default: begin
                d.fmt     = FMT_UNKNOWN;
                d.illegal = 1'b1;
                d.rd      = w[11:7];    // Raw fields and a zero immediate
                d.rs1     = w[19:15];
                d.rs2     = w[24:20];
                d.funct3  = w[14:12];
                d.funct7  = w[31:25];
                d.shamt   = w[24:20];
            end
        endcase
        return d;
    endfunction

    task automatic check_record(input string name, input decoded_t exp, input decoded_t act);
        if (act !== exp) begin
            $display("error t=%0t %s expected %h got %h", $time, name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error t=%0t %s expected %b got %b", $time, name, exp, act);
            test_errors++;
        end
    endtask

    // Check the result of the last edge and drive the next input
    task automatic step(input logic valid, input logic [31:0] insn, input logic [31:0] pc,
                        input decoded_t exp);
        decoded_t front;
        @(negedge clk);
        check_bit("dec_valid_o", last_valid, dec_valid_o);
        if (dec_valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("record came out at %0t with no instruction outstanding", $time);
                test_errors++;
            end else begin
                front = exp_q.pop_front();
                check_record("dec_o", front, dec_o);
                held = front;
            end
        end else begin
            check_record("dec_o", held, dec_o);   // Must hold through the bubble
        end
        valid_i = valid;
        insn_i  = insn;
        pc_i    = pc;
        if (valid) begin
            exp_q.push_back(exp);
        end
        last_valid = valid;
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("[pass] %s", name);
        end else begin
            fail_count++;
            $display("[fail] %s (%0d errors)", name, test_errors);
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] v_insn;
        logic [31:0] v_pc;
        logic [31:0] v_imm;
        logic [4:0]  v_rd;
        logic [4:0]  v_rs1;
        logic [4:0]  v_rs2;
        logic [4:0]  v_shamt;
        logic [2:0]  v_f3;
        logic [2:0]  v_fmt;
        logic [6:0]  v_f7;
        logic        v_ill;
        decoded_t    exp;
        load_ok = 1'b1;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("cannot open vector file %s", VEC_FILE);
            load_ok = 1'b0;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line[0] != "#") begin   // Skip column notes
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", v_insn, v_pc,
                                v_rd, v_rs1, v_rs2, v_f3, v_f7, v_shamt, v_fmt, v_ill, v_imm);
                    if (n == 11) begin
                        exp         = '0;
                        exp.pc      = v_pc;
                        exp.insn    = v_insn;
                        exp.opcode  = v_insn[6:0];
                        exp.rd      = v_rd;
                        exp.rs1     = v_rs1;
                        exp.rs2     = v_rs2;
                        exp.funct3  = v_f3;
                        exp.funct7  = v_f7;
                        exp.shamt   = v_shamt;
                        exp.fmt     = insn_fmt_e'(v_fmt);
                        exp.illegal = v_ill;
                        exp.imm     = v_imm;
                        vec_insn.push_back(v_insn);
                        vec_pc.push_back(v_pc);
                        vec_exp.push_back(exp);
                    end else if (n > 0) begin
                        $display("malformed line in %s: %s", VEC_FILE, line);
                        load_ok = 1'b0;
                    end
                end
            end
            $fclose(fd);
            if (vec_exp.size() == 0) begin
                $display("no vectors found in %s", VEC_FILE);
                load_ok = 1'b0;
            end
        end
    endtask

    initial begin : main
        logic [31:0] word;
        logic [31:0] pc;
        logic [31:0] ctl;
        $timeformat(-9, 0, " ns", 0);
        clk        = 1'b0;
        reset_i    = 1'b1;
        valid_i    = 1'b0;
        insn_i     = '0;
        pc_i       = '0;
        held       = '0;
        last_valid = 1'b0;
        rng        = 32'd39622;
        pass_count = 0;
        fail_count = 0;
        load_vectors();
        loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        test_errors = 0;
        // State left by reset alone while reset_i is still high
        check_bit("dec_valid_o", 1'b0, dec_valid_o);
        check_record("dec_o", '0, dec_o);
        reset_i = 1'b0;

        // Idle after reset with all outputs zero
        repeat (4) step(1'b0, 32'h0, 32'h0, '0);
        finish_test("reset state");

        if (!load_ok) begin
            fail_count++;
            $display("[fail] directed vectors could not be read");
        end else begin
            for (int v = 0; v < vec_exp.size(); v++) begin
                test_errors = 0;
                step(1'b1, vec_insn[v], vec_pc[v], vec_exp[v]);
                step(1'b0, ~vec_insn[v], ~vec_pc[v], '0);   // Junk on the bus while idle
                finish_test($sformatf("vector %0d insn %h", v, vec_insn[v]));
            end
        end

        // Back-to-back stream with random bubbles
        test_errors = 0;
        for (int k = 0; k < NUM_RANDOM; k++) begin
            rng  = xorshift32(rng);
            word = rng;
            rng  = xorshift32(rng);
            pc   = {rng[31:2], 2'b00};
            rng  = xorshift32(rng);
            ctl  = rng;
            word[6:0] = pick_opcode(ctl);
            step(1'b1, word, pc, model_decode(word, pc));
            if (ctl[31:29] < 3'd3) begin
                rng = xorshift32(rng);
                step(1'b0, rng, ~rng, '0);
            end
        end
        step(1'b0, 32'h0, 32'h0, '0);   // Drain the last record
        if (exp_q.size() != 0) begin
            $display("%0d records never came out of the stage", exp_q.size());
            test_errors++;
        end
        finish_test($sformatf("random stream of %0d instructions", NUM_RANDOM));

        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Two cycles per vector and at most two per random instruction, plus reset slack
    initial begin : watchdog
        wait (loaded);
        #((2 * vec_exp.size() + 2 * NUM_RANDOM + 64) * CLK_PERIOD);
        $display("run timed out before all records arrived");
        $display("=== FAIL ===");
        $finish;
    end

endmodule : tb_decode
